//--- verilog/rv64_pkg.sv
`default_nettype none

package rv64_pkg;

	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 5;

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [ALU_OP_W-1:0]   alu_op_t;
	typedef logic [1:0]            mem_op_t;
	typedef logic [1:0]            size_t;

	// alu operation codes
	localparam alu_op_t ALU_ADD   = 5'd0;
	localparam alu_op_t ALU_SUB   = 5'd1;
	localparam alu_op_t ALU_SLL   = 5'd2;
	localparam alu_op_t ALU_SLT   = 5'd3;
	localparam alu_op_t ALU_SLTU  = 5'd4;
	localparam alu_op_t ALU_XOR   = 5'd5;
	localparam alu_op_t ALU_SRL   = 5'd6;
	localparam alu_op_t ALU_SRA   = 5'd7;
	localparam alu_op_t ALU_OR    = 5'd8;
	localparam alu_op_t ALU_AND   = 5'd9;
	localparam alu_op_t ALU_ADDW  = 5'd10; // word ops sign-extend bit 31
	localparam alu_op_t ALU_SUBW  = 5'd11;
	localparam alu_op_t ALU_SLLW  = 5'd12;
	localparam alu_op_t ALU_SRLW  = 5'd13;
	localparam alu_op_t ALU_SRAW  = 5'd14;
	localparam alu_op_t ALU_PASS2 = 5'd15; // lui

	localparam mem_op_t MEM_NONE  = 2'd0;
	localparam mem_op_t MEM_LOAD  = 2'd1;
	localparam mem_op_t MEM_STORE = 2'd2;

	localparam size_t SIZE_B = 2'd0;
	localparam size_t SIZE_H = 2'd1;
	localparam size_t SIZE_W = 2'd2;
	localparam size_t SIZE_D = 2'd3;

	localparam xlen_t RESET_PC = 64'h8000_0000;

	// 256 double words give an 11-bit byte address
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

endpackage

`default_nettype wire

//--- verilog/ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
	input  wire                  valid_i,
	input  rv64_pkg::alu_op_t    alu_op_i,
	input  rv64_pkg::xlen_t      alu_src1_i,
	input  rv64_pkg::xlen_t      alu_src2_i,
	input  wire [31:0]           s_imm_i,
	input  rv64_pkg::mem_op_t    mem_op_i,
	input  rv64_pkg::size_t      size_i,
	input  wire                  unsigned_i,
	input  wire                  reg_wen_i,
	input  rv64_pkg::reg_addr_t  reg_waddr_i,
	input  wire                  ebreak_i,
	input  rv64_pkg::xlen_t      pc_i,
	output logic                 valid_o,
	output rv64_pkg::xlen_t      result_o,
	output rv64_pkg::xlen_t      store_data_o,
	output logic [7:0]           wmask_o,
	output rv64_pkg::mem_op_t    mem_op_o,
	output rv64_pkg::size_t      size_o,
	output logic                 unsigned_o,
	output logic                 reg_wen_o,
	output rv64_pkg::reg_addr_t  reg_waddr_o,
	output logic                 ebreak_o,
	output rv64_pkg::xlen_t      pc_o
);

	rv64_pkg::xlen_t alu_res;
	rv64_pkg::xlen_t eff_addr;
	logic [31:0]     word_res;
	logic            word_op;
	logic [7:0]      size_mask;
	logic            aligned;

	always_comb begin
		word_res = 32'd0;
		word_op  = 1'b0;
		case (alu_op_i)
			rv64_pkg::ALU_ADD:   alu_res = alu_src1_i + alu_src2_i;
			rv64_pkg::ALU_SUB:   alu_res = alu_src1_i - alu_src2_i;
			rv64_pkg::ALU_SLL:   alu_res = alu_src1_i << alu_src2_i[5:0];
			rv64_pkg::ALU_SLT:   alu_res = {63'd0, $signed(alu_src1_i) < $signed(alu_src2_i)};
			rv64_pkg::ALU_SLTU:  alu_res = {63'd0, alu_src1_i < alu_src2_i};
			rv64_pkg::ALU_XOR:   alu_res = alu_src1_i ^ alu_src2_i;
			rv64_pkg::ALU_SRL:   alu_res = alu_src1_i >> alu_src2_i[5:0];
			rv64_pkg::ALU_SRA:   alu_res = $signed(alu_src1_i) >>> alu_src2_i[5:0];
			rv64_pkg::ALU_OR:    alu_res = alu_src1_i | alu_src2_i;
			rv64_pkg::ALU_AND:   alu_res = alu_src1_i & alu_src2_i;
			rv64_pkg::ALU_PASS2: alu_res = alu_src2_i;
			default: begin
				alu_res = '0;
				word_op = 1'b1; // w ops land here and are replaced below
				case (alu_op_i)
					rv64_pkg::ALU_ADDW: word_res = alu_src1_i[31:0] + alu_src2_i[31:0];
					rv64_pkg::ALU_SUBW: word_res = alu_src1_i[31:0] - alu_src2_i[31:0];
					rv64_pkg::ALU_SLLW: word_res = alu_src1_i[31:0] << alu_src2_i[4:0];
					rv64_pkg::ALU_SRLW: word_res = alu_src1_i[31:0] >> alu_src2_i[4:0];
					rv64_pkg::ALU_SRAW: word_res = $signed(alu_src1_i[31:0]) >>> alu_src2_i[4:0];
					default:            word_op  = 1'b0; // unknown code gives zero
				endcase
			end
		endcase
		if (word_op) begin
			alu_res = {{32{word_res[31]}}, word_res};
		end
	end

	// loads and stores use base plus sign-extended offset
	assign eff_addr = alu_src1_i + {{32{s_imm_i[31]}}, s_imm_i};

	always_comb begin
		case (size_i)
			rv64_pkg::SIZE_B: size_mask = 8'h01;
			rv64_pkg::SIZE_H: size_mask = 8'h03;
			rv64_pkg::SIZE_W: size_mask = 8'h0f;
			default:          size_mask = 8'hff;
		endcase
	end

	always_comb begin
		case (size_i)
			rv64_pkg::SIZE_H: aligned = (eff_addr[0] == 1'b0);
			rv64_pkg::SIZE_W: aligned = (eff_addr[1:0] == 2'b00);
			rv64_pkg::SIZE_D: aligned = (eff_addr[2:0] == 3'b000);
			default:          aligned = 1'b1;
		endcase
	end

	assign result_o     = (mem_op_i != rv64_pkg::MEM_NONE) ? eff_addr : alu_res;
	assign store_data_o = alu_src2_i << {eff_addr[2:0], 3'b000}; // move into byte lane
	assign wmask_o      = (mem_op_i == rv64_pkg::MEM_STORE) ? size_mask << eff_addr[2:0] : 8'h00;

	assign valid_o     = valid_i;
	assign mem_op_o    = mem_op_i;
	assign size_o      = size_i;
	assign unsigned_o  = unsigned_i;
	assign reg_wen_o   = reg_wen_i;
	assign reg_waddr_o = reg_waddr_i;
	assign ebreak_o    = ebreak_i;
	assign pc_o        = pc_i;

	// misaligned accesses would split across two memory words
	always_comb begin
		if (valid_i && mem_op_i != rv64_pkg::MEM_NONE) begin
			assert final (aligned)
				else $error("ex_stage: misaligned access at %h", eff_addr);
		end
	end

endmodule

`default_nettype wire

//--- verilog/ex_mem_regs.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mem_regs (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  stall_i,
	input  wire                  valid_i,
	input  rv64_pkg::xlen_t      result_i,
	input  rv64_pkg::xlen_t      store_data_i,
	input  wire [7:0]            wmask_i,
	input  rv64_pkg::mem_op_t    mem_op_i,
	input  rv64_pkg::size_t      size_i,
	input  wire                  unsigned_i,
	input  wire                  reg_wen_i,
	input  rv64_pkg::reg_addr_t  reg_waddr_i,
	input  wire                  ebreak_i,
	input  rv64_pkg::xlen_t      pc_i,
	output logic                 valid_o,
	output rv64_pkg::xlen_t      result_o,
	output rv64_pkg::xlen_t      store_data_o,
	output logic [7:0]           wmask_o,
	output rv64_pkg::mem_op_t    mem_op_o,
	output rv64_pkg::size_t      size_o,
	output logic                 unsigned_o,
	output logic                 reg_wen_o,
	output rv64_pkg::reg_addr_t  reg_waddr_o,
	output logic                 ebreak_o,
	output rv64_pkg::xlen_t      pc_o
);

	// control fields cleared at reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_o   <= 1'b0;
			wmask_o   <= 8'h00;
			mem_op_o  <= rv64_pkg::MEM_NONE;
			reg_wen_o <= 1'b0;
			ebreak_o  <= 1'b0;
			pc_o      <= rv64_pkg::RESET_PC;
		end else if (!stall_i) begin
			valid_o   <= valid_i;
			wmask_o   <= wmask_i;
			mem_op_o  <= mem_op_i;
			reg_wen_o <= reg_wen_i;
			ebreak_o  <= ebreak_i;
			pc_o      <= pc_i;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			result_o     <= result_i;
			store_data_o <= store_data_i;
			size_o       <= size_i;
			unsigned_o   <= unsigned_i;
			reg_waddr_o  <= reg_waddr_i;
		end
	end

	// only a load waiting in the register may freeze it
	a_stall_on_load: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall_i |-> valid_o && (mem_op_o == rv64_pkg::MEM_LOAD)
	) else $error("ex_mem_regs: stalled without a load in the register");

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  valid_i,
	input  rv64_pkg::xlen_t      result_i,
	input  rv64_pkg::xlen_t      store_data_i,
	input  wire [7:0]            wmask_i,
	input  rv64_pkg::mem_op_t    mem_op_i,
	input  rv64_pkg::size_t      size_i,
	input  wire                  unsigned_i,
	input  wire                  reg_wen_i,
	input  rv64_pkg::reg_addr_t  reg_waddr_i,
	input  wire                  ebreak_i,
	input  rv64_pkg::xlen_t      pc_i,
	output logic                 stall_o,
	output logic                 wb_valid_o,
	output logic                 wb_wen_o,
	output rv64_pkg::reg_addr_t  wb_waddr_o,
	output rv64_pkg::xlen_t      wb_wdata_o,
	output rv64_pkg::xlen_t      wb_pc_o,
	output logic                 wb_ebreak_o
);

	rv64_pkg::xlen_t                 dmem [rv64_pkg::DMEM_WORDS];
	rv64_pkg::xlen_t                 rdata_q;    // word read in the load's first cycle
	rv64_pkg::xlen_t                 lane_data;
	rv64_pkg::xlen_t                 load_data;
	logic [rv64_pkg::DMEM_IDX_W-1:0] word_idx;
	logic [2:0]                      byte_off;
	logic                            is_load;
	logic                            is_store;
	logic                            load_phase; // high in second load cycle
	logic                            wb_fire;

	assign word_idx = result_i[rv64_pkg::DMEM_IDX_W+2:3];
	assign byte_off = result_i[2:0];
	assign is_load  = valid_i && (mem_op_i == rv64_pkg::MEM_LOAD);
	assign is_store = valid_i && (mem_op_i == rv64_pkg::MEM_STORE);

	// first load cycle holds EX/MEM
	assign stall_o = is_load && !load_phase;
	assign wb_fire = valid_i && !stall_o;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_phase <= 1'b0;
		end else begin
			load_phase <= stall_o;
		end
	end

	// data memory with byte-masked writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int w = 0; w < rv64_pkg::DMEM_WORDS; w++) begin
				dmem[w] <= '0;
			end
		end else if (is_store) begin
			for (int b = 0; b < 8; b++) begin
				if (wmask_i[b]) begin
					dmem[word_idx][b*8 +: 8] <= store_data_i[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stall_o) begin
			rdata_q <= dmem[word_idx];
		end
	end

	// pick the lane then extend by size
	assign lane_data = rdata_q >> {byte_off, 3'b000};

	always_comb begin
		case (size_i)
			rv64_pkg::SIZE_B: load_data = {{56{!unsigned_i && lane_data[7]}}, lane_data[7:0]};
			rv64_pkg::SIZE_H: load_data = {{48{!unsigned_i && lane_data[15]}}, lane_data[15:0]};
			rv64_pkg::SIZE_W: load_data = {{32{!unsigned_i && lane_data[31]}}, lane_data[31:0]};
			default:          load_data = lane_data;
		endcase
	end

	// write-back register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_o  <= 1'b0;
			wb_wen_o    <= 1'b0;
			wb_ebreak_o <= 1'b0;
			wb_pc_o     <= rv64_pkg::RESET_PC;
		end else begin
			wb_valid_o  <= wb_fire;
			wb_wen_o    <= wb_fire && !is_store && reg_wen_i && (reg_waddr_i != '0); // x0 stays 0
			wb_ebreak_o <= wb_fire && ebreak_i;
			if (wb_fire) begin
				wb_pc_o <= pc_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb_fire) begin
			wb_waddr_o <= reg_waddr_i;
			wb_wdata_o <= is_load ? load_data : result_i;
		end
	end

	// the held load comes back for its second cycle without a second bubble
	a_stall_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall_o |=> is_load && !stall_o
	) else $error("mem_stage: load not held for exactly one stall cycle");

endmodule

`default_nettype wire

//--- verilog/rv64_ex_mem.sv
`timescale 1ns/1ns
`default_nettype none

module rv64_ex_mem (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  valid_i,
	input  rv64_pkg::alu_op_t    alu_op_i,
	input  rv64_pkg::xlen_t      alu_src1_i,
	input  rv64_pkg::xlen_t      alu_src2_i,
	input  wire [31:0]           s_imm_i,
	input  rv64_pkg::mem_op_t    mem_op_i,
	input  rv64_pkg::size_t      size_i,
	input  wire                  unsigned_i,
	input  wire                  reg_wen_i,
	input  rv64_pkg::reg_addr_t  reg_waddr_i,
	input  wire                  ebreak_i,
	input  rv64_pkg::xlen_t      pc_i,
	output logic                 stall_o,
	output logic                 wb_valid_o,
	output logic                 wb_wen_o,
	output rv64_pkg::reg_addr_t  wb_waddr_o,
	output rv64_pkg::xlen_t      wb_wdata_o,
	output rv64_pkg::xlen_t      wb_pc_o,
	output logic                 wb_ebreak_o
);

	// execute outputs
	logic                ex_valid, ex_unsigned, ex_reg_wen, ex_ebreak;
	rv64_pkg::xlen_t     ex_result, ex_store_data, ex_pc;
	logic [7:0]          ex_wmask;
	rv64_pkg::mem_op_t   ex_mem_op;
	rv64_pkg::size_t     ex_size;
	rv64_pkg::reg_addr_t ex_reg_waddr;

	// EX/MEM register outputs
	logic                mem_valid, mem_unsigned, mem_reg_wen, mem_ebreak;
	rv64_pkg::xlen_t     mem_result, mem_store_data, mem_pc;
	logic [7:0]          mem_wmask;
	rv64_pkg::mem_op_t   mem_mem_op;
	rv64_pkg::size_t     mem_size;
	rv64_pkg::reg_addr_t mem_reg_waddr;

	ex_stage i_ex_stage (
		.valid_i      (valid_i),
		.alu_op_i     (alu_op_i),
		.alu_src1_i   (alu_src1_i),
		.alu_src2_i   (alu_src2_i),
		.s_imm_i      (s_imm_i),
		.mem_op_i     (mem_op_i),
		.size_i       (size_i),
		.unsigned_i   (unsigned_i),
		.reg_wen_i    (reg_wen_i),
		.reg_waddr_i  (reg_waddr_i),
		.ebreak_i     (ebreak_i),
		.pc_i         (pc_i),
		.valid_o      (ex_valid),
		.result_o     (ex_result),
		.store_data_o (ex_store_data),
		.wmask_o      (ex_wmask),
		.mem_op_o     (ex_mem_op),
		.size_o       (ex_size),
		.unsigned_o   (ex_unsigned),
		.reg_wen_o    (ex_reg_wen),
		.reg_waddr_o  (ex_reg_waddr),
		.ebreak_o     (ex_ebreak),
		.pc_o         (ex_pc)
	);

	ex_mem_regs i_ex_mem_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall_i      (stall_o),
		.valid_i      (ex_valid),
		.result_i     (ex_result),
		.store_data_i (ex_store_data),
		.wmask_i      (ex_wmask),
		.mem_op_i     (ex_mem_op),
		.size_i       (ex_size),
		.unsigned_i   (ex_unsigned),
		.reg_wen_i    (ex_reg_wen),
		.reg_waddr_i  (ex_reg_waddr),
		.ebreak_i     (ex_ebreak),
		.pc_i         (ex_pc),
		.valid_o      (mem_valid),
		.result_o     (mem_result),
		.store_data_o (mem_store_data),
		.wmask_o      (mem_wmask),
		.mem_op_o     (mem_mem_op),
		.size_o       (mem_size),
		.unsigned_o   (mem_unsigned),
		.reg_wen_o    (mem_reg_wen),
		.reg_waddr_o  (mem_reg_waddr),
		.ebreak_o     (mem_ebreak),
		.pc_o         (mem_pc)
	);

	mem_stage i_mem_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid_i      (mem_valid),
		.result_i     (mem_result),
		.store_data_i (mem_store_data),
		.wmask_i      (mem_wmask),
		.mem_op_i     (mem_mem_op),
		.size_i       (mem_size),
		.unsigned_i   (mem_unsigned),
		.reg_wen_i    (mem_reg_wen),
		.reg_waddr_i  (mem_reg_waddr),
		.ebreak_i     (mem_ebreak),
		.pc_i         (mem_pc),
		.stall_o      (stall_o),      // also freezes EX/MEM
		.wb_valid_o   (wb_valid_o),
		.wb_wen_o     (wb_wen_o),
		.wb_waddr_o   (wb_waddr_o),
		.wb_wdata_o   (wb_wdata_o),
		.wb_pc_o      (wb_pc_o),
		.wb_ebreak_o  (wb_ebreak_o)
	);

endmodule

`default_nettype wire

//--- verif/tb_rv64_ex_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv64_ex_mem;

	localparam string INPUT_FILE = "verif/ex_mem_input.txt";

	typedef struct packed {
		logic                valid;
		rv64_pkg::alu_op_t   alu_op;
		rv64_pkg::xlen_t     src1;
		rv64_pkg::xlen_t     src2;
		logic [31:0]         s_imm;
		rv64_pkg::mem_op_t   mem_op;
		rv64_pkg::size_t     size;
		logic                uns;
		logic                reg_wen;
		rv64_pkg::reg_addr_t waddr;
		logic                ebreak;
		rv64_pkg::xlen_t     exp_wdata;
		logic                exp_wen;
	} op_t;

	typedef struct packed {
		rv64_pkg::xlen_t     wdata;
		logic                wen;
		rv64_pkg::reg_addr_t waddr;
		logic                ebreak;
		rv64_pkg::xlen_t     pc;
	} wb_rec_t;

	logic                clk;
	logic                rst_n;
	logic                valid_i;
	rv64_pkg::alu_op_t   alu_op_i;
	rv64_pkg::xlen_t     alu_src1_i;
	rv64_pkg::xlen_t     alu_src2_i;
	logic [31:0]         s_imm_i;
	rv64_pkg::mem_op_t   mem_op_i;
	rv64_pkg::size_t     size_i;
	logic                unsigned_i;
	logic                reg_wen_i;
	rv64_pkg::reg_addr_t reg_waddr_i;
	logic                ebreak_i;
	rv64_pkg::xlen_t     pc_i;
	logic                stall_o;
	logic                wb_valid_o;
	logic                wb_wen_o;
	rv64_pkg::reg_addr_t wb_waddr_o;
	rv64_pkg::xlen_t     wb_wdata_o;
	rv64_pkg::xlen_t     wb_pc_o;
	logic                wb_ebreak_o;

	op_t     ops[$];
	wb_rec_t exp_q[$];       // accepted ops in input order
	integer  seed = 36226;
	int      data_errs;
	int      addr_errs;
	int      flag_errs;
	int      proto_errs;
	int      loads_accepted;
	int      stall_cycles;
	logic    stall_prev;
	bit      loaded;

	rv64_ex_mem i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.valid_i     (valid_i),
		.alu_op_i    (alu_op_i),
		.alu_src1_i  (alu_src1_i),
		.alu_src2_i  (alu_src2_i),
		.s_imm_i     (s_imm_i),
		.mem_op_i    (mem_op_i),
		.size_i      (size_i),
		.unsigned_i  (unsigned_i),
		.reg_wen_i   (reg_wen_i),
		.reg_waddr_i (reg_waddr_i),
		.ebreak_i    (ebreak_i),
		.pc_i        (pc_i),
		.stall_o     (stall_o),
		.wb_valid_o  (wb_valid_o),
		.wb_wen_o    (wb_wen_o),
		.wb_waddr_o  (wb_waddr_o),
		.wb_wdata_o  (wb_wdata_o),
		.wb_pc_o     (wb_pc_o),
		.wb_ebreak_o (wb_ebreak_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare_data(input string what, input rv64_pkg::xlen_t got,
			input rv64_pkg::xlen_t exp);
		if (got !== exp) begin
			data_errs++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_addr(input string what, input rv64_pkg::reg_addr_t got,
			input rv64_pkg::reg_addr_t exp);
		if (got !== exp) begin
			addr_errs++;
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errs++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("errors: data %0d, addr %0d, flag %0d, protocol %0d",
			data_errs, addr_errs, flag_errs, proto_errs);
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		print_counts();
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// lines that do not hold all 13 columns are skipped
	task automatic read_ops();
		int          fd;
		int          n;
		string       line;
		logic [63:0] f [0:12];
		op_t         op;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verif/ex_mem_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
					f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
				if (n == 13) begin
					op.valid     = f[0][0];
					op.alu_op    = f[1][4:0];
					op.src1      = f[2];
					op.src2      = f[3];
					op.s_imm     = f[4][31:0];
					op.mem_op    = f[5][1:0];
					op.size      = f[6][1:0];
					op.uns       = f[7][0];
					op.reg_wen   = f[8][0];
					op.waddr     = f[9][4:0];
					op.ebreak    = f[10][0];
					op.exp_wdata = f[11];
					op.exp_wen   = f[12][0];
					ops.push_back(op);
				end
			end
			$fclose(fd);
		end
	endtask

	// drive on the edge and look at stall_o between edges
	task automatic drive_op(input op_t op, input rv64_pkg::xlen_t pc);
		wb_rec_t rec;
		@(posedge clk);
		valid_i     <= op.valid;
		alu_op_i    <= op.alu_op;
		alu_src1_i  <= op.src1;
		alu_src2_i  <= op.src2;
		s_imm_i     <= op.s_imm;
		mem_op_i    <= op.mem_op;
		size_i      <= op.size;
		unsigned_i  <= op.uns;
		reg_wen_i   <= op.reg_wen;
		reg_waddr_i <= op.waddr;
		ebreak_i    <= op.ebreak;
		pc_i        <= pc;
		@(negedge clk);
		while (stall_o) begin
			@(negedge clk);
		end
		if (op.valid) begin   // taken at the coming edge
			rec.wdata  = op.exp_wdata;
			rec.wen    = op.exp_wen;
			rec.waddr  = op.waddr;
			rec.ebreak = op.ebreak;
			rec.pc     = pc;
			exp_q.push_back(rec);
			if (op.mem_op == rv64_pkg::MEM_LOAD) begin
				loads_accepted++;
			end
		end
	endtask

	task automatic insert_bubbles(input int n);
		repeat (n) begin
			@(posedge clk);
			valid_i <= 1'b0;
		end
	endtask

	task automatic check_reset_state();
		compare_flag("stall_o after reset", stall_o, 1'b0);
		compare_flag("wb_valid_o after reset", wb_valid_o, 1'b0);
		compare_flag("wb_wen_o after reset", wb_wen_o, 1'b0);
		compare_flag("wb_ebreak_o after reset", wb_ebreak_o, 1'b0);
		compare_data("wb_pc_o after reset", wb_pc_o, rv64_pkg::RESET_PC);
	endtask

	// write-back monitor and stall length check
	always @(negedge clk) begin
		wb_rec_t rec;
		if (rst_n) begin
			if (stall_o) begin
				stall_cycles++;
			end
			if (stall_o && stall_prev) begin
				proto_errs++;
				$display("stall_o stayed high for two cycles in a row at %0t ns", $time);
			end
			stall_prev = stall_o;
			if (wb_valid_o) begin
				if (exp_q.size() == 0) begin
					proto_errs++;
					$display("write-back record at %0t ns with no operation outstanding", $time);
				end else begin
					rec = exp_q.pop_front();
					compare_data("wb_wdata_o", wb_wdata_o, rec.wdata);
					compare_data("wb_pc_o", wb_pc_o, rec.pc);
					compare_addr("wb_waddr_o", wb_waddr_o, rec.waddr);
					compare_flag("wb_wen_o", wb_wen_o, rec.wen);
					compare_flag("wb_ebreak_o", wb_ebreak_o, rec.ebreak);
				end
			end else begin
				compare_flag("wb_wen_o without wb_valid_o", wb_wen_o, 1'b0);
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (ops.size() * 4 + 20) @(posedge clk);
		abort_run("watchdog expired: the DUT stopped returning write-back records");
	end

	initial begin
		int              gap;
		rv64_pkg::xlen_t pc;
		rst_n       = 1'b0;
		valid_i     = 1'b0;
		alu_op_i    = rv64_pkg::ALU_ADD;
		alu_src1_i  = '0;
		alu_src2_i  = '0;
		s_imm_i     = '0;
		mem_op_i    = rv64_pkg::MEM_NONE;
		size_i      = rv64_pkg::SIZE_B;
		unsigned_i  = 1'b0;
		reg_wen_i   = 1'b0;
		reg_waddr_i = '0;
		ebreak_i    = 1'b0;
		pc_i        = rv64_pkg::RESET_PC;
		stall_prev  = 1'b0;
		read_ops();
		if (ops.size() == 0) begin
			abort_run("no operations could be read from verif/ex_mem_input.txt");
		end else begin
			loaded = 1'b1;
			repeat (3) @(posedge clk);
			rst_n <= 1'b1;
			@(negedge clk);
			check_reset_state();
			pc = rv64_pkg::RESET_PC;
			foreach (ops[i]) begin
				drive_op(ops[i], pc);
				pc = pc + 64'd4;
				gap = $unsigned($random(seed)) % 3;
				insert_bubbles(gap);
			end
			@(posedge clk);
			valid_i <= 1'b0;
			while (exp_q.size() != 0) begin
				@(negedge clk);
			end
			repeat (2) @(negedge clk);   // catch late extra records
			if (stall_cycles != loads_accepted) begin
				proto_errs++;
				$display("saw %0d stall cycles for %0d loads", stall_cycles, loads_accepted);
			end
			print_counts();
			if (data_errs + addr_errs + flag_errs + proto_errs == 0) begin
				$display("Simulation finished: PASS");
			end else begin
				$display("Simulation finished: FAIL");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/ex_mem_input.txt
# valid alu_op src1 src2 s_imm mem_op size unsigned reg_wen waddr ebreak exp_wdata exp_wen (hex)
1 0 7fffffffffffffff 0000000000000001 00000000 0 0 0 1 01 0 8000000000000000 1
1 1 0000000000000005 0000000000000007 00000000 0 0 0 1 02 0 fffffffffffffffe 1
1 2 0000000000000001 0000000000000043 00000000 0 0 0 1 03 0 0000000000000008 1
1 3 ffffffffffffffff 0000000000000001 00000000 0 0 0 1 04 0 0000000000000001 1
1 4 ffffffffffffffff 0000000000000001 00000000 0 0 0 1 05 0 0000000000000000 1
1 5 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 00000000 0 0 0 1 06 0 0ff00ff00ff00ff0 1
1 6 8000000000000000 0000000000000004 00000000 0 0 0 1 07 0 0800000000000000 1
1 7 8000000000000000 0000000000000004 00000000 0 0 0 1 08 0 f800000000000000 1
1 8 f0f0f0f0f0f0f0f0 0f0f0000000000ff 00000000 0 0 0 1 09 0 fffff0f0f0f0f0ff 1
1 9 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 00000000 0 0 0 1 0a 0 f000f000f000f000 1
1 a 000000007fffffff 0000000000000001 00000000 0 0 0 1 0b 0 ffffffff80000000 1
1 b 0000000100000000 0000000000000001 00000000 0 0 0 1 0c 0 ffffffffffffffff 1
1 c 0000000000000001 000000000000003f 00000000 0 0 0 1 0d 0 ffffffff80000000 1
1 d ffffffff80000000 0000000000000004 00000000 0 0 0 1 0e 0 0000000008000000 1
1 e 0000000080000000 0000000000000004 00000000 0 0 0 1 0f 0 fffffffff8000000 1
1 f 0000000000001234 0000000012345000 00000000 0 0 0 1 10 1 0000000012345000 1
1 0 0000000000000100 8877665544332211 00000000 2 3 0 1 12 0 0000000000000100 0
1 0 0000000000000100 00000000000000a5 00000003 2 0 0 0 00 0 0000000000000103 0
1 0 0000000000000108 000000000000beef 00000002 2 1 0 0 00 0 000000000000010a 0
1 0 0000000000000118 00000000cafef00d fffffffc 2 2 0 0 00 0 0000000000000114 0
0 0 0000000000000000 0000000000000000 00000000 0 0 0 0 00 0 0000000000000000 0
1 0 0000000000000100 0000000000000000 00000000 1 3 0 1 13 0 88776655a5332211 1
1 0 0000000000000100 0000000000000000 00000003 1 0 0 1 14 0 ffffffffffffffa5 1
1 0 0000000000000100 0000000000000000 00000003 1 0 1 1 15 0 00000000000000a5 1
1 0 0000000000000102 0000000000000000 00000000 1 0 0 1 16 0 0000000000000033 1
1 0 0000000000000110 0000000000000000 fffffffa 1 1 0 1 17 0 ffffffffffffbeef 1
1 0 000000000000010a 0000000000000000 00000000 1 1 1 1 18 0 000000000000beef 1
1 0 0000000000000114 0000000000000000 00000000 1 2 0 1 19 1 ffffffffcafef00d 1
1 0 0000000000000110 0000000000000000 00000004 1 2 1 1 1a 0 00000000cafef00d 1
1 0 0000000000000104 0000000000000000 00000000 1 2 0 1 1b 0 ffffffff88776655 1
1 0 0000000000000100 0000000000000000 00000000 1 3 0 1 00 0 88776655a5332211 0
1 0 0000000000000001 0000000000000002 00000000 0 0 0 1 00 0 0000000000000003 0

//--- rv64_ex_mem.f
verilog/rv64_pkg.sv
verilog/ex_stage.sv
verilog/ex_mem_regs.sv
verilog/mem_stage.sv
verilog/rv64_ex_mem.sv
verif/tb_rv64_ex_mem.sv

//--- Bender.yml
package:
  name: rv64_ex_mem

sources:
  - verilog/rv64_pkg.sv
  - verilog/ex_stage.sv
  - verilog/ex_mem_regs.sv
  - verilog/mem_stage.sv
  - verilog/rv64_ex_mem.sv
  - target: test
    files:
      - verif/tb_rv64_ex_mem.sv
